// ==== source/sched_consts.svh ====
/*
 * Sizing constants for the issue scheduler.
 * Included by the package, the interfaces and every RTL stage that needs a size.
 */
`ifndef SCHED_CONSTS_SVH
`define SCHED_CONSTS_SVH

// Number of reorder buffer entries, kept a power of two so an index wraps naturally
`define SCHED_ROB_ENTRIES 16

// Entries examined per cycle, counted from the head
`define SCHED_WINDOW_SIZE 12

// Execution unit counts
`define SCHED_NALU 2
`define SCHED_NAGEN 2

// Zero keeps flow-control ops issuing strictly in program order
`define SCHED_SUPPORT_OOOFC 0

`endif

// ==== source/sched_pkg.sv ====
/*
 * Shared types of the issue scheduler.
 * Other files refer to these by scoped names and never import the package.
 */
`default_nettype none

`include "sched_consts.svh"

package sched_pkg;

	// Index of one reorder buffer entry
	typedef logic [$clog2(`SCHED_ROB_ENTRIES)-1:0] rob_ndx_t;

	// One bit per reorder buffer entry
	typedef logic [`SCHED_ROB_ENTRIES-1:0] rob_mask_t;

	// Done or in-flight pair, bit 0 is the main result and bit 1 the flow-control part
	typedef logic [1:0] rob_pair_t;

	// Operation class decoded for each entry
	typedef enum logic [2:0] {
		OP_NONE = 3'd0,
		OP_ALU  = 3'd1,
		OP_ALU0 = 3'd2,	// may only run on ALU0
		OP_FC   = 3'd3,
		OP_MEM  = 3'd4,
		OP_SYNC = 3'd5
	} op_class_e;

endpackage

`default_nettype wire

// ==== source/sched_ifs.sv ====
/*
 * Internal buses of the scheduler.
 * cand_if moves registered candidates to the selector and grant_if moves
 * the selector decisions to the output registers.
 */
`default_nettype none

`include "sched_consts.svh"

// Candidate information, written by the two registered stages
interface cand_if;
	sched_pkg::rob_mask_t can_issue;
	sched_pkg::rob_ndx_t heads [`SCHED_WINDOW_SIZE];
	sched_pkg::rob_mask_t prior_sync;
	sched_pkg::rob_mask_t prior_fc;
	sched_pkg::op_class_e cls [`SCHED_ROB_ENTRIES];
	sched_pkg::rob_pair_t done [`SCHED_ROB_ENTRIES];
	sched_pkg::rob_pair_t inflight [`SCHED_ROB_ENTRIES];

	modport ready_src (output can_issue);
	modport order_src (output heads, prior_sync, prior_fc, cls, done, inflight);
	modport sel (input can_issue, heads, prior_sync, prior_fc, cls, done, inflight);
endinterface

// Per-unit grants and the issue masks that go with them
interface grant_if;
	logic alu0_v, alu1_v, fcu_v, agen0_v, agen1_v;
	sched_pkg::rob_ndx_t alu0_ndx, alu1_ndx, fcu_ndx, agen0_ndx, agen1_ndx;
	sched_pkg::rob_mask_t alu_mask;
	sched_pkg::rob_mask_t fcu_mask;
	sched_pkg::rob_mask_t agen_mask;

	modport src (output alu0_v, alu1_v, fcu_v, agen0_v, agen1_v,
		alu0_ndx, alu1_ndx, fcu_ndx, agen0_ndx, agen1_ndx,
		alu_mask, fcu_mask, agen_mask);
	modport sink (input alu0_v, alu1_v, fcu_v, agen0_v, agen1_v,
		alu0_ndx, alu1_ndx, fcu_ndx, agen0_ndx, agen1_ndx,
		alu_mask, fcu_mask, agen_mask);
endinterface

`default_nettype wire

// ==== source/entry_ready.sv ====
/*
 * Per-entry readiness stage of the scheduler.
 * Evaluates operand, stomp and done state over the whole ROB at once and
 * registers the result, so it reaches the selector one clock after sampling.
 */
`default_nettype none

`include "sched_consts.svh"

module entry_ready (
	input wire logic clk,
	input wire logic rst,
	input wire sched_pkg::rob_mask_t stomp_i,
	input wire sched_pkg::rob_mask_t rob_v_i,
	input wire sched_pkg::rob_pair_t rob_done_i [`SCHED_ROB_ENTRIES],
	input wire sched_pkg::rob_mask_t rob_arga_v_i,
	input wire sched_pkg::rob_mask_t rob_argb_v_i,
	input wire sched_pkg::rob_mask_t rob_argc_v_i,
	input wire sched_pkg::op_class_e rob_class_i [`SCHED_ROB_ENTRIES],
	cand_if.ready_src cand
);

	// Entries whose source operands are all available
	sched_pkg::rob_mask_t args_ok;

	// Entries that are live and still have work to do
	sched_pkg::rob_mask_t live;

	// Next value of the registered readiness mask
	sched_pkg::rob_mask_t ready_d;

	// ==================================================================
	// Operand check
	// ==================================================================

	// Memory ops take their third operand later, at the store data path,
	// so argument C is not waited on for them
	always_comb begin
		for (int i = 0; i < `SCHED_ROB_ENTRIES; i++) begin
			args_ok[i] = rob_arga_v_i[i] && rob_argb_v_i[i]
				&& (rob_argc_v_i[i] || rob_class_i[i] == sched_pkg::OP_MEM);
		end
	end

	// ==================================================================
	// Entry state check
	// ==================================================================

	// An entry is only worth looking at when valid, not being squashed and
	// not yet complete in both of its parts
	always_comb begin
		for (int i = 0; i < `SCHED_ROB_ENTRIES; i++) begin
			live[i] = rob_v_i[i] && !stomp_i[i] && !(&rob_done_i[i]);
		end
	end

	assign ready_d = live & args_ok;

	// Registered readiness mask, read by the selector one clock after sampling
	always_ff @(posedge clk) begin
		if (rst) begin
			cand.can_issue <= '0;
		end else begin
			cand.can_issue <= ready_d;
		end
	end

endmodule

`default_nettype wire

// ==== source/order_scan.sv ====
/*
 * Ordering stage of the scheduler.
 * Registers the window of indices from the head, copies of the entry state,
 * and for every entry whether a sync or an unfinished flow-control op is older.
 */
`default_nettype none

`include "sched_consts.svh"

module order_scan (
	input wire logic clk,
	input wire logic rst,
	input wire sched_pkg::rob_ndx_t head_i,
	input wire sched_pkg::rob_mask_t rob_v_i,
	input wire sched_pkg::op_class_e rob_class_i [`SCHED_ROB_ENTRIES],
	input wire sched_pkg::rob_pair_t rob_done_i [`SCHED_ROB_ENTRIES],
	input wire sched_pkg::rob_pair_t rob_out_i [`SCHED_ROB_ENTRIES],
	cand_if.order_src cand
);

	sched_pkg::rob_mask_t prior_sync_d;
	sched_pkg::rob_mask_t prior_fc_d;

	// Walk the whole ROB from the head, oldest first. Each entry records
	// what was seen before it, then adds its own contribution
	always_comb begin
		logic seen_sync;
		logic seen_fc;
		sched_pkg::rob_ndx_t idx;
		seen_sync = 1'b0;
		seen_fc = 1'b0;
		prior_sync_d = '0;
		prior_fc_d = '0;
		for (int k = 0; k < `SCHED_ROB_ENTRIES; k++) begin
			idx = sched_pkg::rob_ndx_t'((head_i + k) % `SCHED_ROB_ENTRIES);
			prior_sync_d[idx] = seen_sync;
			prior_fc_d[idx] = seen_fc;
			if (rob_v_i[idx] && rob_class_i[idx] == sched_pkg::OP_SYNC)
				seen_sync = 1'b1;
			// A flow-control op stops blocking once its branch part is done
			if (rob_v_i[idx] && rob_class_i[idx] == sched_pkg::OP_FC && !rob_done_i[idx][1])
				seen_fc = 1'b1;
		end
	end

	// Registered barrier flags for the selector
	always_ff @(posedge clk) begin
		if (rst) begin
			cand.prior_sync <= '0;
			cand.prior_fc <= '0;
		end else begin
			cand.prior_sync <= prior_sync_d;
			cand.prior_fc <= prior_fc_d;
		end
	end

	// Window indices and entry copies, aligned in time with the readiness mask
	always_ff @(posedge clk) begin
		for (int m = 0; m < `SCHED_WINDOW_SIZE; m++)
			cand.heads[m] <= sched_pkg::rob_ndx_t'((head_i + m) % `SCHED_ROB_ENTRIES);
		cand.cls <= rob_class_i;
		cand.done <= rob_done_i;
		cand.inflight <= rob_out_i;
	end

endmodule

`default_nettype wire

// ==== source/issue_select.sv ====
/*
 * Issue selector of the scheduler.
 * Combinational walk over the window from oldest to youngest, picking at most
 * one entry per execution unit. Idle inputs are used directly.
 */
`default_nettype none

`include "sched_consts.svh"

module issue_select (
	input wire logic alu0_idle_i,
	input wire logic alu1_idle_i,
	input wire logic fcu_idle_i,
	input wire logic agen0_idle_i,
	input wire logic agen1_idle_i,
	cand_if.sel cand,
	grant_if.src grant
);

	logic alu0_v, alu1_v, fcu_v, agen0_v, agen1_v;
	sched_pkg::rob_ndx_t alu0_ndx, alu1_ndx, fcu_ndx, agen0_ndx, agen1_ndx;
	sched_pkg::rob_mask_t alu_mask, fcu_mask, agen_mask;

	// ==================================================================
	// Window walk
	// ==================================================================

	// Earlier positions in the loop are older, so the first match wins
	always_comb begin
		sched_pkg::rob_ndx_t idx;
		sched_pkg::op_class_e cls;
		logic main_free;
		logic fc_free;
		logic eligible;
		alu0_v = 1'b0;
		alu1_v = 1'b0;
		fcu_v = 1'b0;
		agen0_v = 1'b0;
		agen1_v = 1'b0;
		alu0_ndx = '0;
		alu1_ndx = '0;
		fcu_ndx = '0;
		agen0_ndx = '0;
		agen1_ndx = '0;
		alu_mask = '0;
		fcu_mask = '0;
		agen_mask = '0;
		for (int k = 0; k < `SCHED_WINDOW_SIZE; k++) begin
			idx = cand.heads[k];
			cls = cand.cls[idx];
			// Main result neither produced nor already on its way
			main_free = !cand.done[idx][0] && !cand.inflight[idx][0];
			fc_free = !cand.done[idx][1] && !cand.inflight[idx][1];
			// Anything behind a sync waits for the sync to retire
			eligible = cand.can_issue[idx] && !cand.prior_sync[idx];
			if (eligible) begin
				// ALU0 accepts both general and ALU0-only ops
				if (!alu0_v && alu0_idle_i && main_free
					&& (cls == sched_pkg::OP_ALU || cls == sched_pkg::OP_ALU0)) begin
					alu0_v = 1'b1;
					alu0_ndx = idx;
					alu_mask[idx] = 1'b1;
				end
				// ALU1 only takes general ops that ALU0 left behind
				if (`SCHED_NALU > 1 && !alu1_v && alu1_idle_i && main_free
					&& cls == sched_pkg::OP_ALU && !alu_mask[idx]) begin
					alu1_v = 1'b1;
					alu1_ndx = idx;
					alu_mask[idx] = 1'b1;
				end
				// Flow control goes one at a time and in program order
				if (!fcu_v && fcu_idle_i && fc_free && cls == sched_pkg::OP_FC
					&& (`SCHED_SUPPORT_OOOFC != 0 || !cand.prior_fc[idx])) begin
					fcu_v = 1'b1;
					fcu_ndx = idx;
					fcu_mask[idx] = 1'b1;
				end
				if (!agen0_v && agen0_idle_i && main_free && cls == sched_pkg::OP_MEM) begin
					agen0_v = 1'b1;
					agen0_ndx = idx;
					agen_mask[idx] = 1'b1;
				end
				if (`SCHED_NAGEN > 1 && !agen1_v && agen1_idle_i && main_free
					&& cls == sched_pkg::OP_MEM && !agen_mask[idx]) begin
					agen1_v = 1'b1;
					agen1_ndx = idx;
					agen_mask[idx] = 1'b1;
				end
			end
		end
	end

	// Hand the decisions to the output registers
	assign grant.alu0_v = alu0_v;
	assign grant.alu1_v = alu1_v;
	assign grant.fcu_v = fcu_v;
	assign grant.agen0_v = agen0_v;
	assign grant.agen1_v = agen1_v;
	assign grant.alu0_ndx = alu0_ndx;
	assign grant.alu1_ndx = alu1_ndx;
	assign grant.fcu_ndx = fcu_ndx;
	assign grant.agen0_ndx = agen0_ndx;
	assign grant.agen1_ndx = agen1_ndx;
	assign grant.alu_mask = alu_mask;
	assign grant.fcu_mask = fcu_mask;
	assign grant.agen_mask = agen_mask;

endmodule

`default_nettype wire

// ==== source/issue_regs.sv ====
/*
 * Output register stage of the scheduler.
 * Captures every grant on the clock after selection and clears them on reset.
 */
`default_nettype none

module issue_regs (
	input wire logic clk,
	input wire logic rst,
	grant_if.sink grant,
	output sched_pkg::rob_mask_t alu_issue_o,
	output sched_pkg::rob_mask_t fcu_issue_o,
	output sched_pkg::rob_mask_t agen_issue_o,
	output sched_pkg::rob_ndx_t alu0_rndx_o,
	output sched_pkg::rob_ndx_t alu1_rndx_o,
	output sched_pkg::rob_ndx_t fcu_rndx_o,
	output sched_pkg::rob_ndx_t agen0_rndx_o,
	output sched_pkg::rob_ndx_t agen1_rndx_o,
	output logic alu0_rndxv_o,
	output logic alu1_rndxv_o,
	output logic fcu_rndxv_o,
	output logic agen0_rndxv_o,
	output logic agen1_rndxv_o
);

	// Grants are levels that last one cycle and repeat while conditions hold.
	// An index with its valid bit low is forced to zero
	always_ff @(posedge clk) begin
		if (rst) begin
			alu_issue_o <= '0;
			fcu_issue_o <= '0;
			agen_issue_o <= '0;
			alu0_rndx_o <= '0;
			alu1_rndx_o <= '0;
			fcu_rndx_o <= '0;
			agen0_rndx_o <= '0;
			agen1_rndx_o <= '0;
			alu0_rndxv_o <= 1'b0;
			alu1_rndxv_o <= 1'b0;
			fcu_rndxv_o <= 1'b0;
			agen0_rndxv_o <= 1'b0;
			agen1_rndxv_o <= 1'b0;
		end else begin
			alu_issue_o <= grant.alu_mask;
			fcu_issue_o <= grant.fcu_mask;
			agen_issue_o <= grant.agen_mask;
			alu0_rndx_o <= grant.alu0_v ? grant.alu0_ndx : '0;
			alu1_rndx_o <= grant.alu1_v ? grant.alu1_ndx : '0;
			fcu_rndx_o <= grant.fcu_v ? grant.fcu_ndx : '0;
			agen0_rndx_o <= grant.agen0_v ? grant.agen0_ndx : '0;
			agen1_rndx_o <= grant.agen1_v ? grant.agen1_ndx : '0;
			alu0_rndxv_o <= grant.alu0_v;
			alu1_rndxv_o <= grant.alu1_v;
			fcu_rndxv_o <= grant.fcu_v;
			agen0_rndxv_o <= grant.agen0_v;
			agen1_rndxv_o <= grant.agen1_v;
		end
	end

endmodule

`default_nettype wire

// ==== source/sched_top.sv ====
/*
 * Top level of the issue scheduler.
 * Takes a ROB snapshot and unit idle levels on plain ports and returns the
 * registered grants. ROB changes show two clocks later, idle changes one.
 */
`default_nettype none

`include "sched_consts.svh"

module sched_top (
	input wire logic clk,
	input wire logic rst,
	input wire sched_pkg::rob_ndx_t head_i,
	input wire sched_pkg::rob_mask_t stomp_i,
	input wire sched_pkg::rob_mask_t rob_v_i,
	input wire sched_pkg::rob_pair_t rob_done_i [`SCHED_ROB_ENTRIES],
	input wire sched_pkg::rob_pair_t rob_out_i [`SCHED_ROB_ENTRIES],
	input wire sched_pkg::rob_mask_t rob_arga_v_i,
	input wire sched_pkg::rob_mask_t rob_argb_v_i,
	input wire sched_pkg::rob_mask_t rob_argc_v_i,
	input wire sched_pkg::op_class_e rob_class_i [`SCHED_ROB_ENTRIES],
	input wire logic alu0_idle_i,
	input wire logic alu1_idle_i,
	input wire logic fcu_idle_i,
	input wire logic agen0_idle_i,
	input wire logic agen1_idle_i,
	output sched_pkg::rob_mask_t alu_issue_o,
	output sched_pkg::rob_mask_t fcu_issue_o,
	output sched_pkg::rob_mask_t agen_issue_o,
	output sched_pkg::rob_ndx_t alu0_rndx_o,
	output sched_pkg::rob_ndx_t alu1_rndx_o,
	output sched_pkg::rob_ndx_t fcu_rndx_o,
	output sched_pkg::rob_ndx_t agen0_rndx_o,
	output sched_pkg::rob_ndx_t agen1_rndx_o,
	output logic alu0_rndxv_o,
	output logic alu1_rndxv_o,
	output logic fcu_rndxv_o,
	output logic agen0_rndxv_o,
	output logic agen1_rndxv_o
);

	cand_if cand ();
	grant_if grant ();

	// ==================================================================
	// First stage, registered view of the ROB
	// ==================================================================

	entry_ready i_entry_ready (
		.clk(clk), .rst(rst), .stomp_i(stomp_i), .rob_v_i(rob_v_i),
		.rob_done_i(rob_done_i), .rob_arga_v_i(rob_arga_v_i),
		.rob_argb_v_i(rob_argb_v_i), .rob_argc_v_i(rob_argc_v_i),
		.rob_class_i(rob_class_i), .cand(cand.ready_src)
	);

	order_scan i_order_scan (
		.clk(clk), .rst(rst), .head_i(head_i), .rob_v_i(rob_v_i),
		.rob_class_i(rob_class_i), .rob_done_i(rob_done_i),
		.rob_out_i(rob_out_i), .cand(cand.order_src)
	);

	// ==================================================================
	// Second stage, selection and output registers
	// ==================================================================

	issue_select i_issue_select (
		.alu0_idle_i(alu0_idle_i), .alu1_idle_i(alu1_idle_i), .fcu_idle_i(fcu_idle_i),
		.agen0_idle_i(agen0_idle_i), .agen1_idle_i(agen1_idle_i),
		.cand(cand.sel), .grant(grant.src)
	);

	issue_regs i_issue_regs (
		.clk(clk), .rst(rst), .grant(grant.sink),
		.alu_issue_o(alu_issue_o), .fcu_issue_o(fcu_issue_o),
		.agen_issue_o(agen_issue_o),
		.alu0_rndx_o(alu0_rndx_o), .alu1_rndx_o(alu1_rndx_o), .fcu_rndx_o(fcu_rndx_o),
		.agen0_rndx_o(agen0_rndx_o), .agen1_rndx_o(agen1_rndx_o),
		.alu0_rndxv_o(alu0_rndxv_o), .alu1_rndxv_o(alu1_rndxv_o),
		.fcu_rndxv_o(fcu_rndxv_o), .agen0_rndxv_o(agen0_rndxv_o),
		.agen1_rndxv_o(agen1_rndxv_o)
	);

endmodule

`default_nettype wire

// ==== verif/sched_checker.sv ====
/*
 * Protocol assertions on the scheduler outputs.
 * Bound to sched_top from the testbench and watches the registered grants.
 */
`default_nettype none

module sched_checker (
	input wire logic clk,
	input wire logic rst,
	input wire sched_pkg::rob_mask_t alu_issue_i,
	input wire sched_pkg::rob_mask_t fcu_issue_i,
	input wire sched_pkg::rob_mask_t agen_issue_i,
	input wire sched_pkg::rob_ndx_t alu0_rndx_i,
	input wire sched_pkg::rob_ndx_t alu1_rndx_i,
	input wire sched_pkg::rob_ndx_t fcu_rndx_i,
	input wire sched_pkg::rob_ndx_t agen0_rndx_i,
	input wire sched_pkg::rob_ndx_t agen1_rndx_i,
	input wire logic alu0_rndxv_i,
	input wire logic alu1_rndxv_i,
	input wire logic fcu_rndxv_i,
	input wire logic agen0_rndxv_i,
	input wire logic agen1_rndxv_i
);
	timeunit 1ns;
	timeprecision 100ps;

	// Running count of failed assertions
	int fail_count = 0;

	// ======================================================================
	// Grant consistency
	// ======================================================================

	// Both ALUs never get the same entry
	a_alu_distinct: assert property (@(posedge clk) disable iff (rst)
		(alu0_rndxv_i && alu1_rndxv_i) |-> alu0_rndx_i != alu1_rndx_i)
		else begin
			fail_count++;
			$error("ALU0 and ALU1 both hold entry %0d", alu0_rndx_i);
		end

	// Only one flow-control op issues per cycle
	a_fcu_single: assert property (@(posedge clk) disable iff (rst) $onehot0(fcu_issue_i))
		else begin
			fail_count++;
			$error("More than one FCU issue bit set, mask %h", fcu_issue_i);
		end

	// Every valid index shows up in its unit mask
	a_alu0_mask: assert property (@(posedge clk) disable iff (rst)
		alu0_rndxv_i |-> alu_issue_i[alu0_rndx_i])
		else begin
			fail_count++;
			$error("ALU0 index not in mask");
		end
	a_alu1_mask: assert property (@(posedge clk) disable iff (rst)
		alu1_rndxv_i |-> alu_issue_i[alu1_rndx_i])
		else begin
			fail_count++;
			$error("ALU1 index not in mask");
		end
	a_fcu_mask: assert property (@(posedge clk) disable iff (rst)
		fcu_rndxv_i |-> fcu_issue_i[fcu_rndx_i])
		else begin
			fail_count++;
			$error("FCU index not in mask");
		end
	a_agen0_mask: assert property (@(posedge clk) disable iff (rst)
		agen0_rndxv_i |-> agen_issue_i[agen0_rndx_i])
		else begin
			fail_count++;
			$error("AGEN0 index not in mask");
		end
	a_agen1_mask: assert property (@(posedge clk) disable iff (rst)
		agen1_rndxv_i |-> agen_issue_i[agen1_rndx_i])
		else begin
			fail_count++;
			$error("AGEN1 index not in mask");
		end

	// A reset cycle leaves every output cleared on the next one
	a_reset_clear: assert property (@(posedge clk)
		rst |=> ((alu_issue_i | fcu_issue_i | agen_issue_i) == '0
		&& {alu0_rndx_i, alu1_rndx_i, fcu_rndx_i, agen0_rndx_i, agen1_rndx_i} == '0
		&& {alu0_rndxv_i, alu1_rndxv_i, fcu_rndxv_i, agen0_rndxv_i, agen1_rndxv_i} == '0))
		else begin
			fail_count++;
			$error("Outputs not cleared after reset");
		end

endmodule

`default_nettype wire

// ==== verif/sched_tb.sv ====
/*
 * Directed testbench for the issue scheduler.
 * Writes ROB images into sched_top, predicts the grants from the issue rules
 * and compares them with the registered outputs once the pipeline has settled.
 */
`default_nettype none

`include "sched_consts.svh"

module sched_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_PERIOD = 40;
	localparam int RESET_CYCLES = 16;
	localparam int RAND_ROUNDS = 24;
	localparam int DIRECTED_CASES = 10;
	// Drive edge, two pipeline edges and half a cycle to sample
	localparam int CASE_CYCLES = 4;
	localparam int TIMEOUT_CYCLES = RESET_CYCLES
		+ (RAND_ROUNDS + DIRECTED_CASES) * CASE_CYCLES + 50;

	logic clk;
	logic rst;
	sched_pkg::rob_ndx_t head;
	sched_pkg::rob_mask_t stomp, rob_v, arga, argb, argc;
	sched_pkg::rob_pair_t rob_done [`SCHED_ROB_ENTRIES];
	sched_pkg::rob_pair_t rob_out [`SCHED_ROB_ENTRIES];
	sched_pkg::op_class_e rob_class [`SCHED_ROB_ENTRIES];
	logic alu0_idle, alu1_idle, fcu_idle, agen0_idle, agen1_idle;
	sched_pkg::rob_mask_t alu_issue, fcu_issue, agen_issue;
	sched_pkg::rob_ndx_t alu0_rndx, alu1_rndx, fcu_rndx, agen0_rndx, agen1_rndx;
	logic alu0_rndxv, alu1_rndxv, fcu_rndxv, agen0_rndxv, agen1_rndxv;

	// Predicted grants, units 0 to 4 are alu0, alu1, fcu, agen0, agen1
	// and the masks are alu, fcu, agen
	sched_pkg::rob_mask_t exp_mask [3];
	sched_pkg::rob_ndx_t exp_ndx [5];
	logic exp_v [5];
	integer seed;
	int checks;
	int errors;
	int assert_fails;

	sched_top i_dut (
		.clk(clk), .rst(rst), .head_i(head), .stomp_i(stomp), .rob_v_i(rob_v),
		.rob_done_i(rob_done), .rob_out_i(rob_out), .rob_arga_v_i(arga),
		.rob_argb_v_i(argb), .rob_argc_v_i(argc), .rob_class_i(rob_class),
		.alu0_idle_i(alu0_idle), .alu1_idle_i(alu1_idle), .fcu_idle_i(fcu_idle),
		.agen0_idle_i(agen0_idle), .agen1_idle_i(agen1_idle),
		.alu_issue_o(alu_issue), .fcu_issue_o(fcu_issue), .agen_issue_o(agen_issue),
		.alu0_rndx_o(alu0_rndx), .alu1_rndx_o(alu1_rndx), .fcu_rndx_o(fcu_rndx),
		.agen0_rndx_o(agen0_rndx), .agen1_rndx_o(agen1_rndx),
		.alu0_rndxv_o(alu0_rndxv), .alu1_rndxv_o(alu1_rndxv), .fcu_rndxv_o(fcu_rndxv),
		.agen0_rndxv_o(agen0_rndxv), .agen1_rndxv_o(agen1_rndxv)
	);

	bind sched_top sched_checker i_checker (
		.clk(clk), .rst(rst), .alu_issue_i(alu_issue_o), .fcu_issue_i(fcu_issue_o),
		.agen_issue_i(agen_issue_o), .alu0_rndx_i(alu0_rndx_o), .alu1_rndx_i(alu1_rndx_o),
		.fcu_rndx_i(fcu_rndx_o), .agen0_rndx_i(agen0_rndx_o), .agen1_rndx_i(agen1_rndx_o),
		.alu0_rndxv_i(alu0_rndxv_o), .alu1_rndxv_i(alu1_rndxv_o),
		.fcu_rndxv_i(fcu_rndxv_o), .agen0_rndxv_i(agen0_rndxv_o),
		.agen1_rndxv_i(agen1_rndxv_o)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// ======================================================================
	// Reference model
	// ======================================================================

	task automatic grant_unit(input int unit, input int idx);
		int m;
		m = (unit < 2) ? 0 : ((unit == 2) ? 1 : 2);
		exp_v[unit] = 1'b1;
		exp_ndx[unit] = sched_pkg::rob_ndx_t'(idx);
		exp_mask[m][idx] = 1'b1;
	endtask

	// No unit granted and every mask empty
	task automatic clear_expected;
		for (int m = 0; m < 3; m++)
			exp_mask[m] = '0;
		for (int u = 0; u < 5; u++) begin
			exp_v[u] = 1'b0;
			exp_ndx[u] = '0;
		end
	endtask

	// Age is the distance from the head, so walking by distance visits oldest first
	task automatic predict_grants;
		int idx;
		logic ready;
		logic main_ok;
		logic older_sync;
		logic older_fc;
		older_sync = 1'b0;
		older_fc = 1'b0;
		clear_expected();
		for (int d = 0; d < `SCHED_ROB_ENTRIES; d++) begin
			idx = (head + d) % `SCHED_ROB_ENTRIES;
			// Memory ops do not wait for operand C
			ready = rob_v[idx] && !stomp[idx] && rob_done[idx] != 2'b11 && arga[idx]
				&& argb[idx] && (argc[idx] || rob_class[idx] == sched_pkg::OP_MEM);
			main_ok = !rob_done[idx][0] && !rob_out[idx][0];
			if (d < `SCHED_WINDOW_SIZE && ready && !older_sync) begin
				case (rob_class[idx])
					sched_pkg::OP_ALU0: begin
						if (main_ok && alu0_idle && !exp_v[0])
							grant_unit(0, idx);
					end
					sched_pkg::OP_ALU: begin
						if (main_ok && alu0_idle && !exp_v[0])
							grant_unit(0, idx);
						else if (main_ok && alu1_idle && !exp_v[1])
							grant_unit(1, idx);
					end
					sched_pkg::OP_MEM: begin
						if (main_ok && agen0_idle && !exp_v[3])
							grant_unit(3, idx);
						else if (main_ok && agen1_idle && !exp_v[4])
							grant_unit(4, idx);
					end
					sched_pkg::OP_FC: begin
						if (!rob_done[idx][1] && !rob_out[idx][1] && !older_fc
							&& fcu_idle && !exp_v[2])
							grant_unit(2, idx);
					end
					default: ;
				endcase
			end
			if (rob_v[idx] && rob_class[idx] == sched_pkg::OP_SYNC)
				older_sync = 1'b1;
			if (rob_v[idx] && rob_class[idx] == sched_pkg::OP_FC && !rob_done[idx][1])
				older_fc = 1'b1;
		end
	endtask

	// ======================================================================
	// Stimulus and checking helpers
	// ======================================================================

	task automatic check_value(input string tname, input string sig,
		input logic [15:0] got, input logic [15:0] want);
		checks++;
		if (got !== want) begin
			errors++;
			$display("[FAIL] %s: %s = 0x%h, expected 0x%h", tname, sig, got, want);
		end
	endtask

	// Every output against the current prediction
	task automatic compare_outputs(input string tname);
		check_value(tname, "alu_issue_o", alu_issue, exp_mask[0]);
		check_value(tname, "fcu_issue_o", fcu_issue, exp_mask[1]);
		check_value(tname, "agen_issue_o", agen_issue, exp_mask[2]);
		check_value(tname, "alu0_rndxv_o", alu0_rndxv, exp_v[0]);
		check_value(tname, "alu1_rndxv_o", alu1_rndxv, exp_v[1]);
		check_value(tname, "fcu_rndxv_o", fcu_rndxv, exp_v[2]);
		check_value(tname, "agen0_rndxv_o", agen0_rndxv, exp_v[3]);
		check_value(tname, "agen1_rndxv_o", agen1_rndxv, exp_v[4]);
		check_value(tname, "alu0_rndx_o", alu0_rndx, exp_ndx[0]);
		check_value(tname, "alu1_rndx_o", alu1_rndx, exp_ndx[1]);
		check_value(tname, "fcu_rndx_o", fcu_rndx, exp_ndx[2]);
		check_value(tname, "agen0_rndx_o", agen0_rndx, exp_ndx[3]);
		check_value(tname, "agen1_rndx_o", agen1_rndx, exp_ndx[4]);
	endtask

	// Waits the given number of rising edges, then samples at the falling edge
	task automatic settle_and_check(input int edges, input string tname);
		repeat (edges) @(posedge clk);
		@(negedge clk);
		predict_grants();
		compare_outputs(tname);
	endtask

	// Outputs must all be low at the next falling edge, whatever the ROB holds
	task automatic check_cleared(input string tname);
		@(negedge clk);
		clear_expected();
		compare_outputs(tname);
	endtask

	// Empty ROB with every operand ready and every unit idle
	task automatic clear_image(input int new_head);
		head <= sched_pkg::rob_ndx_t'(new_head);
		stomp <= '0;
		rob_v <= '0;
		arga <= '1;
		argb <= '1;
		argc <= '1;
		{alu0_idle, alu1_idle, fcu_idle, agen0_idle, agen1_idle} <= 5'b11111;
		for (int i = 0; i < `SCHED_ROB_ENTRIES; i++) begin
			rob_done[i] <= 2'b00;
			rob_out[i] <= 2'b00;
			rob_class[i] <= sched_pkg::OP_NONE;
		end
	endtask

	task automatic put_entry(input int idx, input sched_pkg::op_class_e cls);
		rob_v[idx] <= 1'b1;
		rob_class[idx] <= cls;
	endtask

	// ======================================================================
	// Directed tests
	// ======================================================================

	// Head at 14 so the oldest entries wrap past the end of the ROB
	task automatic test_alu_select;
		@(posedge clk);
		clear_image(14);
		put_entry(14, sched_pkg::OP_ALU);
		rob_out[14] <= 2'b01;
		put_entry(15, sched_pkg::OP_ALU);
		put_entry(0, sched_pkg::OP_ALU);
		put_entry(1, sched_pkg::OP_ALU);
		settle_and_check(2, "alu wrap");
		@(posedge clk);
		clear_image(14);
		put_entry(14, sched_pkg::OP_ALU0);
		put_entry(15, sched_pkg::OP_ALU);
		put_entry(0, sched_pkg::OP_ALU);
		settle_and_check(2, "alu0 only");
	endtask

	task automatic test_readiness;
		int r;
		@(posedge clk);
		clear_image(0);
		for (int i = 0; i < 6; i++)
			put_entry(i, sched_pkg::OP_ALU);
		put_entry(3, sched_pkg::OP_MEM);
		stomp[0] <= 1'b1;
		rob_done[1] <= 2'b11;
		argb[2] <= 1'b0;
		argc[3] <= 1'b0;
		argc[4] <= 1'b0;
		settle_and_check(2, "ready directed");
		// Random images, with idle levels mostly high
		for (int n = 0; n < RAND_ROUNDS; n++) begin
			@(posedge clk);
			head <= sched_pkg::rob_ndx_t'($random(seed));
			rob_v <= sched_pkg::rob_mask_t'($random(seed));
			stomp <= sched_pkg::rob_mask_t'($random(seed) & $random(seed));
			arga <= sched_pkg::rob_mask_t'($random(seed) | $random(seed));
			argb <= sched_pkg::rob_mask_t'($random(seed) | $random(seed));
			argc <= sched_pkg::rob_mask_t'($random(seed));
			{alu0_idle, alu1_idle, fcu_idle, agen0_idle, agen1_idle}
				<= 5'($random(seed) | $random(seed));
			for (int i = 0; i < `SCHED_ROB_ENTRIES; i++) begin
				r = $random(seed);
				rob_done[i] <= r[1:0] & r[3:2];
				rob_out[i] <= r[5:4] & r[7:6];
				case (r[10:8])
					3'd0, 3'd1, 3'd2: rob_class[i] <= sched_pkg::OP_ALU;
					3'd3, 3'd4: rob_class[i] <= sched_pkg::OP_MEM;
					3'd5: rob_class[i] <= sched_pkg::OP_ALU0;
					3'd6: rob_class[i] <= sched_pkg::OP_FC;
					default: rob_class[i] <= sched_pkg::OP_SYNC;
				endcase
			end
			settle_and_check(2, "ready random");
		end
	endtask

	task automatic test_sync_barrier;
		@(posedge clk);
		clear_image(4);
		put_entry(4, sched_pkg::OP_ALU);
		put_entry(5, sched_pkg::OP_MEM);
		put_entry(6, sched_pkg::OP_SYNC);
		put_entry(7, sched_pkg::OP_ALU);
		put_entry(8, sched_pkg::OP_MEM);
		put_entry(9, sched_pkg::OP_FC);
		settle_and_check(2, "sync barrier");
	endtask

	// The idle level reaches the outputs one edge after it changes
	task automatic test_flow_control;
		@(posedge clk);
		clear_image(0);
		put_entry(2, sched_pkg::OP_FC);
		put_entry(5, sched_pkg::OP_FC);
		settle_and_check(2, "fc in order");
		@(posedge clk);
		rob_done[2] <= 2'b10;
		settle_and_check(2, "fc older done");
		@(posedge clk);
		fcu_idle <= 1'b0;
		settle_and_check(1, "fcu busy");
	endtask

	// Entries 15 and 0 sit at distances 12 and 13 from head 3
	task automatic test_agen_window;
		@(posedge clk);
		clear_image(3);
		put_entry(4, sched_pkg::OP_MEM);
		put_entry(8, sched_pkg::OP_MEM);
		put_entry(9, sched_pkg::OP_MEM);
		settle_and_check(2, "agen order");
		@(posedge clk);
		clear_image(3);
		put_entry(15, sched_pkg::OP_MEM);
		put_entry(0, sched_pkg::OP_MEM);
		put_entry(1, sched_pkg::OP_ALU);
		put_entry(14, sched_pkg::OP_MEM);
		settle_and_check(2, "window edge");
	endtask

	initial begin
		seed = 78160;
		checks = 0;
		errors = 0;
		assert_fails = 0;
		clk = 1'b0;
		rst = 1'b1;
		// Live entries held through reset, none of which may reach the outputs
		clear_image(0);
		put_entry(0, sched_pkg::OP_ALU);
		put_entry(1, sched_pkg::OP_MEM);
		put_entry(2, sched_pkg::OP_FC);
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;
		check_cleared("after reset");
		test_alu_select();
		test_readiness();
		test_sync_barrier();
		test_flow_control();
		test_agen_window();
		assert_fails = i_dut.i_checker.fail_count;
		$display("Summary: %0d checks, %0d errors, %0d assertion failures",
			checks, errors, assert_fails);
		if (errors == 0 && assert_fails == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

	initial begin
		#(TIMEOUT_CYCLES * CLK_PERIOD);
		$display("Timeout: tests still running after %0d cycles", TIMEOUT_CYCLES);
		$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+source
source/sched_pkg.sv
source/sched_ifs.sv
source/entry_ready.sv
source/order_scan.sv
source/issue_select.sv
source/issue_regs.sv
source/sched_top.sv
verif/sched_checker.sv
verif/sched_tb.sv
